// File: Bender.yml
package:
  name: x86_decode

sources:
  - rtl/x86_decode_pkg.sv
  - rtl/prefix_scan.sv
  - rtl/opcode_decode.sv
  - rtl/operand_locate.sv
  - rtl/decode_out_queue.sv
  - rtl/x86_decode_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/clk_gen.sv
      - sim/tb_x86_decode.sv

// File: rtl/decode_out_queue.sv
/*
  decode_out_queue: output FIFO of decoded instructions
  consumer credit counter and fetch credit return
*/
`timescale 1ns/10ps
`default_nettype none

module decode_out_queue #(
  parameter int OUT_DEPTH    = 4,
  parameter int CONS_CREDITS = 2
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          in_valid,
  input  x86_decode_pkg::decoded_inst_t in_inst,
  output logic                          dec_valid,
  output x86_decode_pkg::decoded_inst_t dec_inst,
  input  logic                          dec_credit,
  output logic                          fetch_credit
);
  import x86_decode_pkg::*;

  localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
  localparam int CNT_W = $clog2(OUT_DEPTH + 1);
  localparam int CRD_W = $clog2(CONS_CREDITS + 1);

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
    return (p == PTR_W'(OUT_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  decoded_inst_t    mem [OUT_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CRD_W-1:0] credits;
  logic             pop;

  // head leaves only while the consumer has granted a slot
  assign pop = (credits != '0) && (count != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      credits      <= CRD_W'(CONS_CREDITS);
      dec_valid    <= 1'b0;
      fetch_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count        <= count + CNT_W'(in_valid) - CNT_W'(pop);
      credits      <= credits + CRD_W'(dec_credit) - CRD_W'(pop);
      dec_valid    <= pop;
      // freed slot goes back to fetch
      fetch_credit <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_inst;
    end
    if (pop) begin
      dec_inst <= mem[rd_ptr];
    end
  end

  // fetch credits must keep the stages from overrunning the queue
  assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |-> count < CNT_W'(OUT_DEPTH));

  // consumer returns no more than it was given
  assert property (@(posedge clk) disable iff (!arst_n)
    credits <= CRD_W'(CONS_CREDITS));

endmodule

`default_nettype wire

// File: rtl/opcode_decode.sv
/*
  opcode_decode: second decode stage
  opcode byte selection past the prefixes
  and the one-byte / 0F-map control table
*/
`timescale 1ns/10ps
`default_nettype none

module opcode_decode (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    in_valid,
  input  x86_decode_pkg::s1_pkt_t in_pkt,
  output logic                    out_valid,
  output x86_decode_pkg::s2_pkt_t out_pkt
);
  import x86_decode_pkg::*;

  logic [2:0]  opc_idx;
  byte_t       opcode;
  opcode_ctl_t ctl;

  // opcode sits right after the prefixes and the optional 0F
  assign opc_idx = in_pkt.pfx.count + 3'(in_pkt.pfx.escape);
  assign opcode  = in_pkt.fetch.bytes[opc_idx];

  always_comb begin
    ctl = '0;
    if (in_pkt.pfx.escape) begin
      case (opcode)
        // jz rel32
        8'h84: begin
          ctl.imm_bytes   = IMM_4;
          ctl.imm_shrinks = 1'b1;
        end
        // movq mm, mm/m64
        8'h6F: ctl.modrm_pr = 1'b1;
        default: ctl.illegal = 1'b1;
      endcase
    end else begin
      case (opcode) inside
        8'h01, 8'h03, 8'h89, 8'h8B: ctl.modrm_pr = 1'b1;
        // eAX/reg imm32 forms and near call/jmp rel32
        8'h05, 8'hE8, 8'hE9, [8'hB8:8'hBF]: begin
          ctl.imm_bytes   = IMM_4;
          ctl.imm_shrinks = 1'b1;
        end
        8'h81: begin
          ctl.modrm_pr    = 1'b1;
          ctl.imm_bytes   = IMM_4;
          ctl.imm_shrinks = 1'b1;
        end
        8'h83: begin
          ctl.modrm_pr  = 1'b1;
          ctl.imm_bytes = IMM_1;
        end
        8'hEB: ctl.imm_bytes = IMM_1;
        // nop and ret carry no operand bytes
        8'h90, 8'hC3: ctl.imm_bytes = IMM_0;
        8'hF4: ctl.hlt = 1'b1;
        8'hCF: ctl.iret = 1'b1;
        default: ctl.illegal = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_pkt.s1     <= in_pkt;
      out_pkt.opcode <= opcode;
      out_pkt.ctl    <= ctl;
    end
  end

  // prefix_scan never reports more prefixes than it scans
  assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |-> in_pkt.pfx.count <= 3'(MAX_PREFIXES));

endmodule

`default_nettype wire

// File: rtl/operand_locate.sv
/*
  operand_locate: third decode stage
  ModRM, SIB, displacement and immediate extraction,
  instruction length, next EIP and fetch exception
*/
`timescale 1ns/10ps
`default_nettype none

module operand_locate (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          in_valid,
  input  x86_decode_pkg::s2_pkt_t       in_pkt,
  output logic                          out_valid,
  output x86_decode_pkg::decoded_inst_t out_inst
);
  import x86_decode_pkg::*;

  // four little-endian bytes starting at pos, zero past the window
  function automatic logic [31:0] dword_at(byte_t [WINDOW_BYTES-1:0] win, logic [4:0] pos);
    logic [31:0] d;
    logic [4:0]  idx;
    d = '0;
    for (int k = 0; k < 4; k++) begin
      idx = pos + 5'(k);
      if (idx < 5'(WINDOW_BYTES)) begin
        d[8*k +: 8] = win[idx[3:0]];
      end
    end
    return d;
  endfunction

  logic [4:0]              op_end, disp_pos, imm_pos, len_full;
  logic [2:0]              disp_len, imm_len;
  byte_t                   modrm, sib;
  logic                    sib_pr;
  logic [31:0]             disp_raw, imm_raw, disp32, imm32;
  logic [WINDOW_BYTES-1:0] need_mask;
  logic                    fetch_exp;
  decoded_inst_t           inst;

  // first byte after the opcode
  assign op_end = 5'(in_pkt.s1.pfx.count) + 5'(in_pkt.s1.pfx.escape) + 5'd1;

  assign modrm  = in_pkt.ctl.modrm_pr ? in_pkt.s1.fetch.bytes[op_end[3:0]] : '0;
  assign sib_pr = in_pkt.ctl.modrm_pr && (modrm[7:6] != 2'b11) && (modrm[2:0] == 3'b100);
  assign sib    = sib_pr ? in_pkt.s1.fetch.bytes[op_end[3:0] + 4'd1] : '0;

  always_comb begin
    disp_len = 3'd0;
    if (in_pkt.ctl.modrm_pr) begin
      case (modrm[7:6])
        2'b01: disp_len = 3'd1;
        2'b10: disp_len = 3'd4;
        // disp32 with no base register
        2'b00: begin
          if (modrm[2:0] == 3'b101 || (sib_pr && sib[2:0] == 3'b101)) begin
            disp_len = 3'd4;
          end
        end
        default: disp_len = 3'd0;
      endcase
    end
  end

  always_comb begin
    case (in_pkt.ctl.imm_bytes)
      IMM_1:   imm_len = 3'd1;
      IMM_2:   imm_len = 3'd2;
      // 66 shrinks imm32 / rel32 to 16 bits
      IMM_4:   imm_len = (in_pkt.ctl.imm_shrinks && in_pkt.s1.pfx.opsize) ? 3'd2 : 3'd4;
      default: imm_len = 3'd0;
    endcase
  end

  assign disp_pos = op_end + 5'(in_pkt.ctl.modrm_pr) + 5'(sib_pr);
  assign imm_pos  = disp_pos + 5'(disp_len);
  assign len_full = imm_pos + 5'(imm_len);

  assign disp_raw = dword_at(in_pkt.s1.fetch.bytes, disp_pos);
  assign imm_raw  = dword_at(in_pkt.s1.fetch.bytes, imm_pos);

  always_comb begin
    case (disp_len)
      3'd1:    disp32 = {{24{disp_raw[7]}}, disp_raw[7:0]};
      3'd4:    disp32 = disp_raw;
      default: disp32 = '0;
    endcase
    case (imm_len)
      3'd1:    imm32 = {{24{imm_raw[7]}}, imm_raw[7:0]};
      3'd2:    imm32 = {{16{imm_raw[15]}}, imm_raw[15:0]};
      3'd4:    imm32 = imm_raw;
      default: imm32 = '0;
    endcase
  end

  // every byte below the length must be valid
  always_comb begin
    for (int i = 0; i < WINDOW_BYTES; i++) begin
      need_mask[i] = 5'(i) < len_full;
    end
  end

  assign fetch_exp = |(need_mask & ~in_pkt.s1.fetch.byte_valid);

  always_comb begin
    inst           = '0;
    inst.eip       = in_pkt.s1.fetch.eip;
    inst.length    = len_full[3:0];
    inst.eip_next  = in_pkt.s1.fetch.eip + eip_t'(len_full[3:0]);
    inst.opcode    = in_pkt.opcode;
    inst.two_byte  = in_pkt.s1.pfx.escape;
    inst.modrm     = modrm;
    inst.sib_pr    = sib_pr;
    inst.sib       = sib;
    inst.disp32    = disp32;
    inst.imm32     = imm32;
    inst.seg       = in_pkt.s1.pfx.seg_over_pr ? in_pkt.s1.pfx.seg_over : SEG_DS;
    inst.op_size16 = in_pkt.s1.pfx.opsize;
    inst.repne     = in_pkt.s1.pfx.repne;
    inst.hlt       = in_pkt.ctl.hlt;
    inst.iret      = in_pkt.ctl.iret;
    inst.illegal   = in_pkt.ctl.illegal;
    inst.fetch_exp = fetch_exp;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_inst <= inst;
    end
  end

endmodule

`default_nettype wire

// File: rtl/prefix_scan.sv
/*
  prefix_scan: first decode stage
  leading prefix detection with a thermometer mask,
  prefix count, flag summary and segment override priority
*/
`timescale 1ns/10ps
`default_nettype none

module prefix_scan (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       in_valid,
  input  x86_decode_pkg::fetch_pkt_t in_pkt,
  output logic                       out_valid,
  output x86_decode_pkg::s1_pkt_t    out_pkt
);
  import x86_decode_pkg::*;

  logic [MAX_PREFIXES-1:0] is_repne, is_cs, is_ss, is_ds, is_es, is_fs, is_gs;
  logic [MAX_PREFIXES-1:0] is_opsize, is_esc, is_legacy, is_pfx;
  logic [MAX_PREFIXES-1:0] lead;
  logic [MAX_PREFIXES-1:0] m_cs, m_ss, m_ds, m_es, m_fs, m_gs;
  prefix_info_t            pfx;

  // byte compares on the scanned positions
  always_comb begin
    for (int i = 0; i < MAX_PREFIXES; i++) begin
      is_repne[i]  = in_pkt.bytes[i] == PFX_REPNE;
      is_cs[i]     = in_pkt.bytes[i] == PFX_CS;
      is_ss[i]     = in_pkt.bytes[i] == PFX_SS;
      is_ds[i]     = in_pkt.bytes[i] == PFX_DS;
      is_es[i]     = in_pkt.bytes[i] == PFX_ES;
      is_fs[i]     = in_pkt.bytes[i] == PFX_FS;
      is_gs[i]     = in_pkt.bytes[i] == PFX_GS;
      is_opsize[i] = in_pkt.bytes[i] == PFX_OPSIZE;
      is_esc[i]    = in_pkt.bytes[i] == PFX_ESC;
      is_legacy[i] = is_repne[i] | is_cs[i] | is_ss[i] | is_ds[i] |
                     is_es[i] | is_fs[i] | is_gs[i] | is_opsize[i];
      is_pfx[i]    = is_legacy[i] | is_esc[i];
    end
  end

  // thermometer mask of the leading run
  // 0F ends the run, the next byte is the opcode
  always_comb begin
    lead[0] = is_pfx[0];
    for (int i = 1; i < MAX_PREFIXES; i++) begin
      lead[i] = lead[i-1] & is_pfx[i] & ~is_esc[i-1];
    end
  end

  assign m_cs = lead & is_cs;
  assign m_ss = lead & is_ss;
  assign m_ds = lead & is_ds;
  assign m_es = lead & is_es;
  assign m_fs = lead & is_fs;
  assign m_gs = lead & is_gs;

  always_comb begin
    pfx       = '0;
    pfx.count = 3'd0;
    // count excludes the escape byte
    for (int i = 0; i < MAX_PREFIXES; i++) begin
      pfx.count = pfx.count + 3'(lead[i] & is_legacy[i]);
    end
    pfx.repne       = |(lead & is_repne);
    pfx.opsize      = |(lead & is_opsize);
    pfx.escape      = |(lead & is_esc);
    pfx.seg_over_pr = |{m_es, m_cs, m_ss, m_ds, m_fs, m_gs};
    // ES wins over CS over SS over DS over FS over GS
    if (|m_es) begin
      pfx.seg_over = SEG_ES;
    end else if (|m_cs) begin
      pfx.seg_over = SEG_CS;
    end else if (|m_ss) begin
      pfx.seg_over = SEG_SS;
    end else if (|m_ds) begin
      pfx.seg_over = SEG_DS;
    end else if (|m_fs) begin
      pfx.seg_over = SEG_FS;
    end else begin
      pfx.seg_over = SEG_GS;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_pkt.fetch <= in_pkt;
      out_pkt.pfx   <= pfx;
    end
  end

endmodule

`default_nettype wire

// File: rtl/x86_decode_pkg.sv
/*
  shared definitions for the x86 decode stage
  window geometry, prefix byte codes, segment numbers,
  immediate size codes and the stage packet structs
*/
`default_nettype none

package x86_decode_pkg;

  // fetch window geometry
  localparam int WINDOW_BYTES = 16;
  localparam int MAX_PREFIXES = 4;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] eip_t;
  typedef logic [3:0]  inst_len_t;
  typedef logic [2:0]  seg_sel_t;

  // prefix bytes
  localparam byte_t PFX_REPNE  = 8'hF2;
  localparam byte_t PFX_CS     = 8'h2E;
  localparam byte_t PFX_SS     = 8'h36;
  localparam byte_t PFX_DS     = 8'h3E;
  localparam byte_t PFX_ES     = 8'h26;
  localparam byte_t PFX_FS     = 8'h64;
  localparam byte_t PFX_GS     = 8'h65;
  localparam byte_t PFX_OPSIZE = 8'h66;
  localparam byte_t PFX_ESC    = 8'h0F;

  // segment register numbers, x86 encoding
  localparam seg_sel_t SEG_ES = 3'd0;
  localparam seg_sel_t SEG_CS = 3'd1;
  localparam seg_sel_t SEG_SS = 3'd2;
  localparam seg_sel_t SEG_DS = 3'd3;
  localparam seg_sel_t SEG_FS = 3'd4;
  localparam seg_sel_t SEG_GS = 3'd5;

  // immediate size codes carried in opcode_ctl_t
  localparam logic [1:0] IMM_0 = 2'd0;
  localparam logic [1:0] IMM_1 = 2'd1;
  localparam logic [1:0] IMM_2 = 2'd2;
  localparam logic [1:0] IMM_4 = 2'd3;

  typedef struct packed {
    byte_t [WINDOW_BYTES-1:0] bytes;
    logic  [WINDOW_BYTES-1:0] byte_valid;
    eip_t                     eip;
  } fetch_pkt_t;

  typedef struct packed {
    logic [2:0] count;
    logic       repne;
    logic       opsize;
    logic       escape;
    logic       seg_over_pr;
    seg_sel_t   seg_over;
  } prefix_info_t;

  typedef struct packed {
    logic       modrm_pr;
    logic [1:0] imm_bytes;
    logic       imm_shrinks;
    logic       illegal;
    logic       hlt;
    logic       iret;
  } opcode_ctl_t;

  typedef struct packed {
    fetch_pkt_t   fetch;
    prefix_info_t pfx;
  } s1_pkt_t;

  typedef struct packed {
    s1_pkt_t     s1;
    byte_t       opcode;
    opcode_ctl_t ctl;
  } s2_pkt_t;

  typedef struct packed {
    eip_t        eip;
    eip_t        eip_next;
    inst_len_t   length;
    byte_t       opcode;
    logic        two_byte;
    byte_t       modrm;
    logic        sib_pr;
    byte_t       sib;
    logic [31:0] disp32;
    logic [31:0] imm32;
    seg_sel_t    seg;
    logic        op_size16;
    logic        repne;
    logic        hlt;
    logic        iret;
    logic        illegal;
    logic        fetch_exp;
  } decoded_inst_t;

endpackage

`default_nettype wire

// File: rtl/x86_decode_top.sv
/*
  x86_decode_top: decode stage top level
  prefix scan, opcode decode, operand location, output queue
*/
`timescale 1ns/10ps
`default_nettype none

module x86_decode_top #(
  parameter int OUT_DEPTH    = 4,
  parameter int CONS_CREDITS = 2
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          fetch_valid,
  input  x86_decode_pkg::fetch_pkt_t    fetch_pkt,
  output logic                          fetch_credit,
  output logic                          dec_valid,
  output x86_decode_pkg::decoded_inst_t dec_inst,
  input  logic                          dec_credit
);
  import x86_decode_pkg::*;

  logic          s1_valid, s2_valid, s3_valid;
  s1_pkt_t       s1_pkt;
  s2_pkt_t       s2_pkt;
  decoded_inst_t s3_inst;

  prefix_scan prefix_scan_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (fetch_valid),
    .in_pkt    (fetch_pkt),
    .out_valid (s1_valid),
    .out_pkt   (s1_pkt)
  );

  opcode_decode opcode_decode_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (s1_valid),
    .in_pkt    (s1_pkt),
    .out_valid (s2_valid),
    .out_pkt   (s2_pkt)
  );

  operand_locate operand_locate_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (s2_valid),
    .in_pkt    (s2_pkt),
    .out_valid (s3_valid),
    .out_inst  (s3_inst)
  );

  decode_out_queue #(
    .OUT_DEPTH    (OUT_DEPTH),
    .CONS_CREDITS (CONS_CREDITS)
  ) decode_out_queue_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (s3_valid),
    .in_inst      (s3_inst),
    .dec_valid    (dec_valid),
    .dec_inst     (dec_inst),
    .dec_credit   (dec_credit),
    .fetch_credit (fetch_credit)
  );

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
/*
  clk_gen: testbench clock and active-low reset
*/
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    // release just after the edge
    #1;
    arst_n = 1'b1;
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: sim/decode_vectors.svh
/*
  instruction windows and expected decode results
  columns: name, window (byte 0 leftmost), byte_valid mask, length,
  opcode, modrm, sib, disp32, imm32, segment, flags
  {sib_pr, two_byte, op_size16, repne, hlt, iret, illegal, fetch_exp}
*/
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

task automatic load_vectors();
  // plain one-byte opcodes
  add_vector("nop", 128'h90000000_00000000_00000000_00000000, 16'hFFFF,
             4'd1, 8'h90, 8'h00, 8'h00, 32'h00000000, 32'h00000000, SEG_DS, 8'b00000000);
  add_vector("add_imm32", 128'h05785634_12000000_00000000_00000000, 16'hFFFF,
             4'd5, 8'h05, 8'h00, 8'h00, 32'h00000000, 32'h12345678, SEG_DS, 8'b00000000);
  add_vector("mov_reg_reg", 128'h89C80000_00000000_00000000_00000000, 16'hFFFF,
             4'd2, 8'h89, 8'hC8, 8'h00, 32'h00000000, 32'h00000000, SEG_DS, 8'b00000000);
  add_vector("mov_disp32", 128'h8B054433_22110000_00000000_00000000, 16'hFFFF,
             4'd6, 8'h8B, 8'h05, 8'h00, 32'h11223344, 32'h00000000, SEG_DS, 8'b00000000);
  add_vector("mov_sib_disp8", 128'h8B4424F8_00000000_00000000_00000000, 16'hFFFF,
             4'd4, 8'h8B, 8'h44, 8'h24, 32'hFFFFFFF8, 32'h00000000, SEG_DS, 8'b10000000);
  add_vector("add_disp8_imm32", 128'h814010EF_BEADDE00_00000000_00000000, 16'hFFFF,
             4'd7, 8'h81, 8'h40, 8'h00, 32'h00000010, 32'hDEADBEEF, SEG_DS, 8'b00000000);
  add_vector("add_imm8_sext", 128'h83C08000_00000000_00000000_00000000, 16'hFFFF,
             4'd3, 8'h83, 8'hC0, 8'h00, 32'h00000000, 32'hFFFFFF80, SEG_DS, 8'b00000000);
  // segment override priority
  add_vector("seg_es_over_fs", 128'h64268B00_00000000_00000000_00000000, 16'hFFFF,
             4'd4, 8'h8B, 8'h00, 8'h00, 32'h00000000, 32'h00000000, SEG_ES, 8'b00000000);
  add_vector("seg_cs_over_ss", 128'h362E9000_00000000_00000000_00000000, 16'hFFFF,
             4'd3, 8'h90, 8'h00, 8'h00, 32'h00000000, 32'h00000000, SEG_CS, 8'b00000000);
  add_vector("seg_ss_over_ds", 128'h3E369000_00000000_00000000_00000000, 16'hFFFF,
             4'd3, 8'h90, 8'h00, 8'h00, 32'h00000000, 32'h00000000, SEG_SS, 8'b00000000);
  add_vector("seg_ds_over_fs", 128'h643E9000_00000000_00000000_00000000, 16'hFFFF,
             4'd3, 8'h90, 8'h00, 8'h00, 32'h00000000, 32'h00000000, SEG_DS, 8'b00000000);
  add_vector("seg_fs_over_gs", 128'h65649000_00000000_00000000_00000000, 16'hFFFF,
             4'd3, 8'h90, 8'h00, 8'h00, 32'h00000000, 32'h00000000, SEG_FS, 8'b00000000);
  // operand size and repne
  add_vector("opsize_add", 128'h66050180_00000000_00000000_00000000, 16'hFFFF,
             4'd4, 8'h05, 8'h00, 8'h00, 32'h00000000, 32'hFFFF8001, SEG_DS, 8'b00100000);
  add_vector("opsize_mov", 128'h66B8CDAB_00000000_00000000_00000000, 16'hFFFF,
             4'd4, 8'hB8, 8'h00, 8'h00, 32'h00000000, 32'hFFFFABCD, SEG_DS, 8'b00100000);
  add_vector("opsize_jmp", 128'h66E91000_00000000_00000000_00000000, 16'hFFFF,
             4'd4, 8'hE9, 8'h00, 8'h00, 32'h00000000, 32'h00000010, SEG_DS, 8'b00100000);
  add_vector("repne_nop", 128'hF2900000_00000000_00000000_00000000, 16'hFFFF,
             4'd2, 8'h90, 8'h00, 8'h00, 32'h00000000, 32'h00000000, SEG_DS, 8'b00010000);
  add_vector("late_prefix", 128'h90660000_00000000_00000000_00000000, 16'hFFFF,
             4'd1, 8'h90, 8'h00, 8'h00, 32'h00000000, 32'h00000000, SEG_DS, 8'b00000000);
  // two-byte map, control opcodes, illegal
  add_vector("jz_rel32", 128'h0F840001_00000000_00000000_00000000, 16'hFFFF,
             4'd6, 8'h84, 8'h00, 8'h00, 32'h00000000, 32'h00000100, SEG_DS, 8'b01000000);
  add_vector("movq_modrm", 128'h0F6FC100_00000000_00000000_00000000, 16'hFFFF,
             4'd3, 8'h6F, 8'hC1, 8'h00, 32'h00000000, 32'h00000000, SEG_DS, 8'b01000000);
  add_vector("hlt", 128'hF4000000_00000000_00000000_00000000, 16'hFFFF,
             4'd1, 8'hF4, 8'h00, 8'h00, 32'h00000000, 32'h00000000, SEG_DS, 8'b00001000);
  add_vector("iret", 128'hCF000000_00000000_00000000_00000000, 16'hFFFF,
             4'd1, 8'hCF, 8'h00, 8'h00, 32'h00000000, 32'h00000000, SEG_DS, 8'b00000100);
  add_vector("illegal_d6", 128'hD6000000_00000000_00000000_00000000, 16'hFFFF,
             4'd1, 8'hD6, 8'h00, 8'h00, 32'h00000000, 32'h00000000, SEG_DS, 8'b00000010);
  // valid mask short of the length, then exactly at it
  add_vector("mask_short", 128'h05785634_12000000_00000000_00000000, 16'h000F,
             4'd5, 8'h05, 8'h00, 8'h00, 32'h00000000, 32'h12345678, SEG_DS, 8'b00000001);
  add_vector("mask_exact", 128'h05785634_12000000_00000000_00000000, 16'h001F,
             4'd5, 8'h05, 8'h00, 8'h00, 32'h00000000, 32'h12345678, SEG_DS, 8'b00000000);
endtask

`endif

// File: sim/tb_x86_decode.sv
/*
  tb_x86_decode: testbench top for the x86 decode stage
  drives the vector table under fetch credits, returns consumer
  credits at random and checks each decoded instruction in order
*/
`timescale 1ns/10ps
`default_nettype none

module tb_x86_decode;
  import x86_decode_pkg::*;

  localparam int   OUT_DEPTH    = 4;
  localparam int   CONS_CREDITS = 2;
  localparam int   TIMEOUT      = 300;
  localparam int   HOLD_CYCLES  = 40;
  localparam eip_t EIP_BASE     = 32'h0040_1000;

  // expected flag bits, in table column order
  typedef struct packed {
    logic sib_pr;
    logic two_byte;
    logic op_size16;
    logic repne;
    logic hlt;
    logic iret;
    logic illegal;
    logic fetch_exp;
  } flags_t;

  typedef struct packed {
    logic [127:0] win;
    logic [15:0]  mask;
    inst_len_t    len;
    byte_t        opcode;
    byte_t        modrm;
    byte_t        sib;
    logic [31:0]  disp;
    logic [31:0]  imm;
    seg_sel_t     seg;
    flags_t       flags;
  } vec_t;

  typedef struct packed {
    eip_t        eip;
    eip_t        eip_next;
    inst_len_t   len;
    byte_t       opcode;
    byte_t       modrm;
    byte_t       sib;
    logic [31:0] disp;
    logic [31:0] imm;
    seg_sel_t    seg;
    flags_t      flags;
  } result_t;

  logic          clk;
  logic          arst_n;
  logic          fetch_valid;
  fetch_pkt_t    fetch_pkt;
  logic          fetch_credit;
  logic          dec_valid;
  decoded_inst_t dec_inst;
  logic          dec_credit;

  vec_t  vecs[$];
  string names[$];
  // table rows in flight, oldest first
  int    pending[$];
  int    seed = 85278;
  int    fetch_credits = OUT_DEPTH;
  int    owed;
  int    n_returned;
  int    n_delivered;
  int    n_fcredit;
  int    n_fail;
  int    n_tests;
  int    cycle_cnt;
  bit    timed_out;

  clk_gen #(
    .PERIOD_NS    (4),
    .RESET_CYCLES (2)
  ) clk_gen_inst (
    .clk    (clk),
    .arst_n (arst_n)
  );

  x86_decode_top #(
    .OUT_DEPTH    (OUT_DEPTH),
    .CONS_CREDITS (CONS_CREDITS)
  ) x86_decode_top_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .fetch_valid  (fetch_valid),
    .fetch_pkt    (fetch_pkt),
    .fetch_credit (fetch_credit),
    .dec_valid    (dec_valid),
    .dec_inst     (dec_inst),
    .dec_credit   (dec_credit)
  );

  task automatic add_vector(input string name, input logic [127:0] win,
                            input logic [15:0] mask, input inst_len_t len,
                            input byte_t opcode, input byte_t modrm, input byte_t sib,
                            input logic [31:0] disp, input logic [31:0] imm,
                            input seg_sel_t seg, input flags_t flags);
    vec_t v;
    v = '{win, mask, len, opcode, modrm, sib, disp, imm, seg, flags};
    vecs.push_back(v);
    names.push_back(name);
  endtask

  `include "decode_vectors.svh"

  function automatic eip_t eip_of(input int idx);
    return EIP_BASE + eip_t'(idx * 32);
  endfunction

  function automatic fetch_pkt_t make_pkt(input int idx);
    fetch_pkt_t p;
    // table lists byte 0 first
    for (int i = 0; i < WINDOW_BYTES; i++) begin
      p.bytes[i] = vecs[idx].win[127 - 8*i -: 8];
    end
    p.byte_valid = vecs[idx].mask;
    p.eip        = eip_of(idx);
    return p;
  endfunction

  function automatic string describe(input result_t r);
    return {$sformatf("len=%0d next=%h opc=%h modrm=%h sib=%h ", r.len, r.eip_next,
                      r.opcode, r.modrm, r.sib),
            $sformatf("disp=%h imm=%h seg=%0d flags=%b eip=%h", r.disp, r.imm, r.seg,
                      r.flags, r.eip)};
  endfunction

  // one window per call, only with a fetch credit in hand
  task automatic send_window(input int idx);
    int waited;
    waited = 0;
    while (fetch_credits == 0 && !timed_out) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > TIMEOUT) begin
        $display("timeout: no fetch credit came back for %0s", names[idx]);
        timed_out = 1'b1;
      end
    end
    if (!timed_out) begin
      fetch_pkt   = make_pkt(idx);
      fetch_valid = 1'b1;
      fetch_credits--;
      pending.push_back(idx);
      @(posedge clk);
      #1;
      fetch_valid = 1'b0;
    end
  endtask

  task automatic check_result();
    result_t exp;
    result_t act;
    vec_t    v;
    int      idx;
    n_delivered++;
    assert (n_delivered <= n_returned + CONS_CREDITS) else begin
      n_fail++;
      $display("dec_valid pulse %0d exceeds the consumer credits granted", n_delivered);
    end
    assert (pending.size() != 0) else begin
      n_fail++;
      $display("dec_valid came with no instruction outstanding");
    end
    if (pending.size() != 0) begin
      idx          = pending.pop_front();
      v            = vecs[idx];
      exp.eip      = eip_of(idx);
      exp.eip_next = exp.eip + eip_t'(v.len);
      exp.len      = v.len;
      exp.opcode   = v.opcode;
      exp.modrm    = v.modrm;
      exp.sib      = v.sib;
      exp.disp     = v.disp;
      exp.imm      = v.imm;
      exp.seg      = v.seg;
      exp.flags    = v.flags;
      act.eip      = dec_inst.eip;
      act.eip_next = dec_inst.eip_next;
      act.len      = dec_inst.length;
      act.opcode   = dec_inst.opcode;
      act.modrm    = dec_inst.modrm;
      act.sib      = dec_inst.sib;
      act.disp     = dec_inst.disp32;
      act.imm      = dec_inst.imm32;
      act.seg      = dec_inst.seg;
      act.flags    = {dec_inst.sib_pr, dec_inst.two_byte, dec_inst.op_size16,
                      dec_inst.repne, dec_inst.hlt, dec_inst.iret, dec_inst.illegal,
                      dec_inst.fetch_exp};
      n_tests++;
      assert (act == exp) $display("ok   %0s", names[idx]);
      else begin
        n_fail++;
        $display("Fail %0s expected %0s actual %0s", names[idx], describe(exp),
                 describe(act));
      end
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk) begin
    if (arst_n) begin
      if (fetch_credit) begin
        fetch_credits++;
        n_fcredit++;
      end
      if (dec_valid) begin
        check_result();
        owed++;
      end
    end
  end

  // consumer holds its credits first, then returns them at random
  always @(posedge clk) begin
    #1;
    dec_credit = 1'b0;
    if (arst_n) begin
      cycle_cnt++;
      if (cycle_cnt > HOLD_CYCLES && owed > 0 && ($random(seed) & 1) != 0) begin
        dec_credit = 1'b1;
        owed--;
        n_returned++;
      end
    end
  end

  initial begin : stimulus
    int waited;
    fetch_valid = 1'b0;
    fetch_pkt   = '0;
    dec_credit  = 1'b0;
    load_vectors();
    waited = 0;
    while (!arst_n && !timed_out) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > TIMEOUT) begin
        $display("timeout: reset was never released");
        timed_out = 1'b1;
      end
    end
    for (int i = 0; i < vecs.size() && !timed_out; i++) begin
      send_window(i);
    end
    // drain every result and every consumer credit
    waited = 0;
    while ((pending.size() != 0 || owed != 0) && !timed_out) begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        $display("timeout: %0d results still outstanding", pending.size());
        timed_out = 1'b1;
      end
    end
    assert (fetch_credits == OUT_DEPTH) else begin
      n_fail++;
      $display("fetch holds %0d credits after the drain, not %0d", fetch_credits, OUT_DEPTH);
    end
    assert (n_fcredit == n_delivered) else begin
      n_fail++;
      $display("%0d fetch credits returned for %0d results", n_fcredit, n_delivered);
    end
    $display("%0d of %0d tests checked, %0d failures, %0d consumer credits returned",
             n_tests, vecs.size(), n_fail, n_returned);
    if (n_fail == 0 && !timed_out && n_tests == vecs.size()) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+sim
rtl/x86_decode_pkg.sv
rtl/prefix_scan.sv
rtl/opcode_decode.sv
rtl/operand_locate.sv
rtl/decode_out_queue.sv
rtl/x86_decode_top.sv
sim/clk_gen.sv
sim/tb_x86_decode.sv
